// File: Bender.yml
package:
  name: xm_regs

sources:
  - common/xm_pkg.sv
  - hdl/bus_sync.sv
  - vram_port/vram_port.sv
  - xr_port/xr_port.sv
  - hdl/sys_regs.sv
  - hdl/xm_regs.sv
  - target: test
    files:
      - test/xm_regs_chk.sv
      - test/xm_regs_tb.sv

// File: common/xm_pkg.sv
//*********************************************************************
// xm_pkg
// shared widths, register numbers, timer constants and bus structs
// for the CPU register block of the video controller
//*********************************************************************

package xm_pkg;

typedef logic [7:0]  byte_t;        // one bus byte
typedef logic [15:0] word_t;        // register or memory word
typedef logic [15:0] addr_t;        // VRAM or XR address
typedef logic [3:0]  reg_num_t;     // bus register number
typedef logic [6:0]  intr_t;        // one bit per interrupt source
typedef logic [3:0]  wrmask_t;      // VRAM nibble write enables

// bus register numbers
localparam reg_num_t XM_SYS_CTRL = 4'd0;
localparam reg_num_t XM_INT_CTRL = 4'd1;
localparam reg_num_t XM_TIMER    = 4'd2;
localparam reg_num_t XM_RD_XADDR = 4'd3;
localparam reg_num_t XM_WR_XADDR = 4'd4;
localparam reg_num_t XM_XDATA    = 4'd5;
localparam reg_num_t XM_RD_INCR  = 4'd6;
localparam reg_num_t XM_RD_ADDR  = 4'd7;
localparam reg_num_t XM_WR_INCR  = 4'd8;
localparam reg_num_t XM_WR_ADDR  = 4'd9;
localparam reg_num_t XM_DATA     = 4'd10;
localparam reg_num_t XM_DATA_2   = 4'd11;

// 1/10 ms timer, fractional divide of the pixel clock
localparam int PCLK_HZ           = 25_000_000;
localparam int TIMER_CLK_REDUCED = PCLK_HZ / 1000;
localparam int TIMER_HZ_REDUCED  = 10;
localparam int TIMER_FRAC_BITS   = $clog2(TIMER_CLK_REDUCED) + 1;

localparam logic [TIMER_FRAC_BITS-1:0] TIMER_STEP =
    TIMER_FRAC_BITS'(TIMER_HZ_REDUCED);                         // no tick
localparam logic [TIMER_FRAC_BITS-1:0] TIMER_WRAP =
    TIMER_FRAC_BITS'(TIMER_HZ_REDUCED - TIMER_CLK_REDUCED);     // on tick

typedef struct packed {
    logic     wr_strobe;    // one cycle, byte written
    logic     rd_strobe;    // one cycle, byte read
    reg_num_t reg_num;
    logic     bytesel;      // 0 = even (high) byte
    byte_t    data;
} bus_evt_t;

typedef struct packed {
    logic  sel;
    logic  wr;
    addr_t addr;
    word_t data;            // write data
} mem_req_t;

typedef struct packed {
    word_t   rd_incr;
    addr_t   rd_addr;
    word_t   wr_incr;
    addr_t   wr_addr;
    word_t   data;          // last word read from VRAM
    wrmask_t wrmask;
} vram_view_t;

typedef struct packed {
    addr_t rd_xaddr;
    addr_t wr_xaddr;
    word_t xdata;           // last word read from XR
} xr_view_t;

// replace the addressed byte of a word, even byte is the high one
function automatic word_t put_byte(word_t w, logic odd, byte_t b);
    return odd ? {w[15:8], b} : {b, w[7:0]};
endfunction

endpackage

// File: hdl/bus_sync.sv
//*********************************************************************
// bus_sync
// synchronises the asynchronous CPU bus select and turns each bus
// cycle into a single read or write strobe with held fields
//*********************************************************************

module bus_sync (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire logic             bus_cs_n_i,       // active low select
    input  wire logic             bus_rd_nwr_i,     // 1 = read
    input  wire xm_pkg::reg_num_t bus_reg_num_i,
    input  wire logic             bus_bytesel_i,
    input  wire xm_pkg::byte_t    bus_data_i,
    output      xm_pkg::bus_evt_t bus_evt_o
);

logic [1:0] cs_n_sync;      // two stage synchroniser
logic       cs_n_last;      // previous synchronised level
logic       cs_fall;

assign cs_fall = cs_n_last && !cs_n_sync[1];

always_ff @(posedge clk) begin
    if (reset_i) begin
        cs_n_sync <= 2'b11;
        cs_n_last <= 1'b1;
    end else begin
        cs_n_sync <= {cs_n_sync[0], bus_cs_n_i};
        cs_n_last <= cs_n_sync[1];
    end
end

// strobes, one cycle per bus cycle
always_ff @(posedge clk) begin
    if (reset_i) begin
        bus_evt_o <= '0;
    end else begin
        bus_evt_o.wr_strobe <= cs_fall && !bus_rd_nwr_i;
        bus_evt_o.rd_strobe <= cs_fall && bus_rd_nwr_i;
        // bus fields are stable while selected, held until the next cycle
        if (cs_fall) begin
            bus_evt_o.reg_num <= bus_reg_num_i;
            bus_evt_o.bytesel <= bus_bytesel_i;
            bus_evt_o.data    <= bus_data_i;
        end
    end
end

endmodule

// File: hdl/sys_regs.sv
//*********************************************************************
// sys_regs
// 1/10 ms timer, interrupt mask and clear, status word and the
// bus read-back multiplexer over all registers
//*********************************************************************

module sys_regs (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xm_pkg::bus_evt_t   bus_evt_i,
    input  wire xm_pkg::vram_view_t vram_view_i,
    input  wire xm_pkg::xr_view_t   xr_view_i,
    input  wire logic               vram_busy_i,
    input  wire logic               xr_busy_i,
    input  wire logic               h_blank_i,
    input  wire logic               v_blank_i,
    input  wire xm_pkg::intr_t      intr_status_i,
    output      xm_pkg::intr_t      intr_mask_o,
    output      xm_pkg::intr_t      intr_clear_o,
    output      xm_pkg::byte_t      bus_data_o
);

logic [xm_pkg::TIMER_FRAC_BITS-1:0] timer_frac;    // fractional accumulator
xm_pkg::word_t                      timer;
xm_pkg::byte_t                      timer_latch;   // low byte at high byte read
logic                               tick;
logic                               mem_wait;
xm_pkg::word_t                      rd_word;

assign tick     = !timer_frac[xm_pkg::TIMER_FRAC_BITS-1];
assign mem_wait = vram_busy_i || xr_busy_i;

always_ff @(posedge clk) begin
    if (reset_i) begin
        timer_frac <= '0;
        timer      <= '0;
    end else if (tick) begin
        timer_frac <= timer_frac + xm_pkg::TIMER_WRAP;
        timer      <= timer + 16'd1;
    end else begin
        timer_frac <= timer_frac + xm_pkg::TIMER_STEP;
    end
end

always_ff @(posedge clk) begin
    if (reset_i) begin
        timer_latch  <= '0;
        intr_mask_o  <= '0;
        intr_clear_o <= '0;
    end else begin
        intr_clear_o <= '0;                             // single cycle pulse
        if (bus_evt_i.wr_strobe && (bus_evt_i.reg_num == xm_pkg::XM_INT_CTRL)) begin
            if (bus_evt_i.bytesel) begin
                intr_clear_o <= bus_evt_i.data[6:0];
            end else begin
                intr_mask_o  <= bus_evt_i.data[6:0];
            end
        end
        if (bus_evt_i.rd_strobe && !bus_evt_i.bytesel &&
            (bus_evt_i.reg_num == xm_pkg::XM_TIMER)) begin
            timer_latch <= timer[7:0];
        end
    end
end

// read-back, held register number selects the word
always_comb begin
    case (bus_evt_i.reg_num)
        xm_pkg::XM_SYS_CTRL:
            rd_word = {mem_wait, 3'b0, h_blank_i, v_blank_i, 6'b0, vram_view_i.wrmask};
        xm_pkg::XM_INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
        xm_pkg::XM_TIMER:    rd_word = {timer[15:8], timer_latch};
        xm_pkg::XM_RD_XADDR: rd_word = xr_view_i.rd_xaddr;
        xm_pkg::XM_WR_XADDR: rd_word = xr_view_i.wr_xaddr;
        xm_pkg::XM_XDATA:    rd_word = xr_view_i.xdata;
        xm_pkg::XM_RD_INCR:  rd_word = vram_view_i.rd_incr;
        xm_pkg::XM_RD_ADDR:  rd_word = vram_view_i.rd_addr;
        xm_pkg::XM_WR_INCR:  rd_word = vram_view_i.wr_incr;
        xm_pkg::XM_WR_ADDR:  rd_word = vram_view_i.wr_addr;
        xm_pkg::XM_DATA,
        xm_pkg::XM_DATA_2:   rd_word = vram_view_i.data;
        default:             rd_word = '0;             // 12 to 15 unused
    endcase
end

assign bus_data_o = bus_evt_i.bytesel ? rd_word[7:0] : rd_word[15:8];

endmodule

// File: hdl/xm_regs.sv
//*********************************************************************
// xm_regs
// CPU register block top, bus synchroniser with VRAM and XR ports
// side by side and the system registers
//*********************************************************************

module xm_regs (
    input  wire logic             bus_cs_n_i,
    input  wire logic             bus_rd_nwr_i,     // 1 = read
    input  wire xm_pkg::reg_num_t bus_reg_num_i,
    input  wire logic             bus_bytesel_i,    // 0 = high byte
    input  wire xm_pkg::byte_t    bus_data_i,
    output      xm_pkg::byte_t    bus_data_o,
    input  wire logic             vram_ack_i,
    input  wire xm_pkg::word_t    vram_data_i,
    output      xm_pkg::mem_req_t vram_req_o,
    output      xm_pkg::wrmask_t  vram_wrmask_o,
    input  wire logic             xr_ack_i,
    input  wire xm_pkg::word_t    xr_data_i,
    output      xm_pkg::mem_req_t xr_req_o,
    input  wire logic             h_blank_i,
    input  wire logic             v_blank_i,
    input  wire xm_pkg::intr_t    intr_status_i,
    output      xm_pkg::intr_t    intr_mask_o,
    output      xm_pkg::intr_t    intr_clear_o,
    input  wire logic             clk,              // pixel clock
    input  wire logic             reset_i
);

xm_pkg::bus_evt_t   bus_evt;
xm_pkg::vram_view_t vram_view;
xm_pkg::xr_view_t   xr_view;
logic               vram_busy;
logic               xr_busy;

bus_sync u_bus_sync (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_cs_n_i    (bus_cs_n_i),
    .bus_rd_nwr_i  (bus_rd_nwr_i),
    .bus_reg_num_i (bus_reg_num_i),
    .bus_bytesel_i (bus_bytesel_i),
    .bus_data_i    (bus_data_i),
    .bus_evt_o     (bus_evt)
);

vram_port u_vram_port (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_evt_i     (bus_evt),
    .vram_ack_i    (vram_ack_i),
    .vram_data_i   (vram_data_i),
    .vram_req_o    (vram_req_o),
    .vram_wrmask_o (vram_wrmask_o),
    .vram_view_o   (vram_view),
    .vram_busy_o   (vram_busy)
);

xr_port u_xr_port (
    .clk       (clk),
    .reset_i   (reset_i),
    .bus_evt_i (bus_evt),
    .xr_ack_i  (xr_ack_i),
    .xr_data_i (xr_data_i),
    .xr_req_o  (xr_req_o),
    .xr_view_o (xr_view),
    .xr_busy_o (xr_busy)
);

sys_regs u_sys_regs (
    .clk           (clk),
    .reset_i       (reset_i),
    .bus_evt_i     (bus_evt),
    .vram_view_i   (vram_view),
    .xr_view_i     (xr_view),
    .vram_busy_i   (vram_busy),
    .xr_busy_i     (xr_busy),
    .h_blank_i     (h_blank_i),
    .v_blank_i     (v_blank_i),
    .intr_status_i (intr_status_i),
    .intr_mask_o   (intr_mask_o),
    .intr_clear_o  (intr_clear_o),
    .bus_data_o    (bus_data_o)
);

endmodule

// File: test/xm_regs_chk.sv
//*********************************************************************
// xm_regs_chk
// request and strobe rules for the VRAM and XR ports
//*********************************************************************

module xm_regs_chk (
    input wire logic             clk,
    input wire logic             reset_i,
    input wire xm_pkg::mem_req_t req_i,
    input wire logic             ack_i,
    input wire xm_pkg::bus_evt_t evt_i
);
    timeunit 1ns;
    timeprecision 1ps;

    int fails = 0;          // failed assertion count

    // pending request keeps all fields until acked
    req_hold: assert property (@(posedge clk) disable iff (reset_i)
        (req_i.sel && !ack_i) |=> (req_i.sel && $stable(req_i)))
        else begin
            $error("request changed before ack");
            fails++;
        end

    wr_with_sel: assert property (@(posedge clk) disable iff (reset_i)
        !(req_i.wr && !req_i.sel))
        else begin
            $error("wr high without sel");
            fails++;
        end

    strobe_excl: assert property (@(posedge clk) disable iff (reset_i)
        !(evt_i.wr_strobe && evt_i.rd_strobe))
        else begin
            $error("read and write strobes together");
            fails++;
        end
endmodule

bind vram_port xm_regs_chk vram_chk (.clk(clk), .reset_i(reset_i), .req_i(vram_req_o),
                                     .ack_i(vram_ack_i), .evt_i(bus_evt_i));
bind xr_port xm_regs_chk xr_chk (.clk(clk), .reset_i(reset_i), .req_i(xr_req_o),
                                 .ack_i(xr_ack_i), .evt_i(bus_evt_i));

// File: test/xm_regs_tb.sv
//*********************************************************************
// xm_regs_tb
// testbench for the CPU register block, bus operations and expected
// values come from a data file, VRAM and XR are memory models
//*********************************************************************

module mem_model (
    input  wire logic             clk,
    input  wire xm_pkg::mem_req_t req_i,
    input  wire xm_pkg::wrmask_t  mask_i,
    output      logic             ack_o,
    output      xm_pkg::word_t    data_o
);
    timeunit 1ns;
    timeprecision 1ps;

    xm_pkg::word_t mem [0:65535];
    logic          pending;
    int            wait_cnt;

    initial begin
        for (int a = 0; a < 65536; a++) begin
            mem[a] = xm_pkg::word_t'(a) ^ 16'ha5c3;     // fill depends on all bits
        end
        ack_o    = 1'b0;
        data_o   = '0;
        pending  = 1'b0;
        wait_cnt = 0;
        forever begin
            @(posedge clk);
            #1;
            if (ack_o) begin                            // taken on this edge
                ack_o   = 1'b0;
                pending = 1'b0;
            end else if (req_i.sel) begin
                if (!pending) begin
                    pending  = 1'b1;
                    wait_cnt = 1 + ($urandom % 8);
                end
                wait_cnt--;
                if (wait_cnt == 0) begin
                    ack_o = 1'b1;
                    if (req_i.wr) begin
                        for (int i = 0; i < 4; i++) begin
                            if (mask_i[i]) begin
                                mem[req_i.addr][4*i +: 4] = req_i.data[4*i +: 4];
                            end
                        end
                    end else begin
                        data_o = mem[req_i.addr];
                    end
                end
            end
        end
    end
endmodule

module xm_regs_tb;
    timeunit 1ns;
    timeprecision 1ps;

    logic             clk;
    logic             reset_i;
    logic             bus_cs_n, bus_rd_nwr, bus_bytesel;
    xm_pkg::reg_num_t bus_reg_num;
    xm_pkg::byte_t    bus_din, bus_dout;
    logic             vram_ack, xr_ack, h_blank, v_blank;
    xm_pkg::word_t    vram_rdata, xr_rdata;
    xm_pkg::mem_req_t vram_req, xr_req;
    xm_pkg::wrmask_t  vram_wrmask;
    xm_pkg::intr_t    intr_status, intr_mask, intr_clear, clr_last;
    logic [7:0]       op_q[$];
    int               a_q[$], b_q[$], c_q[$];
    int               errors, bad_tests, clr_count, cycles, limit;
    logic             test_bad;

    xm_regs DUT (
        .bus_cs_n_i(bus_cs_n), .bus_rd_nwr_i(bus_rd_nwr), .bus_reg_num_i(bus_reg_num),
        .bus_bytesel_i(bus_bytesel), .bus_data_i(bus_din), .bus_data_o(bus_dout),
        .vram_ack_i(vram_ack), .vram_data_i(vram_rdata), .vram_req_o(vram_req),
        .vram_wrmask_o(vram_wrmask), .xr_ack_i(xr_ack), .xr_data_i(xr_rdata),
        .xr_req_o(xr_req), .h_blank_i(h_blank), .v_blank_i(v_blank),
        .intr_status_i(intr_status), .intr_mask_o(intr_mask), .intr_clear_o(intr_clear),
        .clk(clk), .reset_i(reset_i)
    );

    mem_model vram_mem (.clk(clk), .req_i(vram_req), .mask_i(vram_wrmask),
                        .ack_o(vram_ack), .data_o(vram_rdata));
    mem_model xr_mem   (.clk(clk), .req_i(xr_req), .mask_i(4'hf),
                        .ack_o(xr_ack), .data_o(xr_rdata));

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // count clear pulses away from the clock edge
    always @(negedge clk) begin
        if (intr_clear != '0) begin
            clr_count++;
            clr_last = intr_clear;
        end
    end

    always @(posedge clk) begin
        cycles++;
    end

    // cycle budget of the loaded tests
    initial begin
        wait (limit > 0 && cycles > limit);
        $display("timeout after %0d cycles, DUT did not finish the tests", cycles);
        $display("TEST FAILED");
        $finish;
    end

    task automatic check_byte(string name, xm_pkg::byte_t got, xm_pkg::byte_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_intr(string name, xm_pkg::intr_t got, xm_pkg::intr_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_word(string name, xm_pkg::word_t got, xm_pkg::word_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    task automatic check_mask(string name, xm_pkg::wrmask_t got, xm_pkg::wrmask_t exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
            test_bad = 1'b1;
        end
    endtask

    // one bus cycle, select held low for 6 clocks
    task automatic bus_cycle(input logic rd, input int r, input int b, input int d,
                             output xm_pkg::byte_t q);
        @(posedge clk);
        #1;
        bus_cs_n    = 1'b0;
        bus_rd_nwr  = rd;
        bus_reg_num = xm_pkg::reg_num_t'(r);
        bus_bytesel = b[0];
        bus_din     = xm_pkg::byte_t'(d);
        repeat (3) @(posedge clk);
        #1;
        q = bus_dout;                                   // valid once strobed
        repeat (3) @(posedge clk);
        #1;
        bus_cs_n = 1'b1;
        repeat (3) @(posedge clk);
        #1;
    endtask

    task automatic load_tests();
        int         fd, a, b, c;
        string      line;
        logic [7:0] op;
        fd = $fopen("test/xm_regs_tests.txt", "r");
        limit = 200;
        if (fd == 0) begin
            $display("could not open the test data file");
            errors++;
        end else begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() < 2 || line[0] == "#") continue;
                a = 0;
                b = 0;
                c = 0;
                void'($sscanf(line, "%c %h %h %h", op, a, b, c));
                op_q.push_back(op);
                a_q.push_back(a);
                b_q.push_back(b);
                c_q.push_back(c);
                case (op)
                    "W", "R": limit += 12;
                    "P":      limit += 200;
                    "I":      limit += a;
                    "T":      limit += 24;
                    default:  limit += 2;
                endcase
            end
            $fclose(fd);
        end
    endtask

    initial begin
        xm_pkg::byte_t q, q_lo;
        xm_pkg::word_t t, t_prev;
        int            d;
        int            asrt_fails;
        void'($urandom(32'h7a06));
        {bus_cs_n, bus_rd_nwr, bus_bytesel} = 3'b100;
        bus_reg_num = '0;
        bus_din     = '0;
        {h_blank, v_blank, intr_status} = '0;
        {errors, bad_tests, clr_count, cycles, limit} = '0;
        clr_last = '0;
        t_prev   = '0;
        reset_i  = 1'b1;
        load_tests();
        repeat (10) @(posedge clk);
        #1;
        reset_i = 1'b0;
        foreach (op_q[i]) begin
            test_bad = 1'b0;
            case (op_q[i])
                "W": bus_cycle(1'b0, a_q[i], b_q[i], c_q[i], q);
                "R": begin
                    bus_cycle(1'b1, a_q[i], b_q[i], 0, q);
                    check_byte($sformatf("bus_data_o reg %0d", a_q[i]), q, c_q[i]);
                end
                "P": begin
                    do bus_cycle(1'b1, xm_pkg::XM_SYS_CTRL, 0, 0, q); while (q[7]);
                end
                "I": repeat (a_q[i]) @(posedge clk);
                "S": begin
                    h_blank     = a_q[i][0];
                    v_blank     = b_q[i][0];
                    intr_status = xm_pkg::intr_t'(c_q[i]);
                end
                "K": check_intr("intr_mask_o", intr_mask, a_q[i]);
                "C": begin
                    if (clr_count != 1) begin
                        $display("expected one intr_clear_o pulse, saw %0d", clr_count);
                        errors++;
                        test_bad = 1'b1;
                    end
                    check_intr("intr_clear_o", clr_last, a_q[i]);
                    clr_count = 0;
                end
                "M": check_mask("vram_wrmask_o", vram_wrmask, a_q[i]);
                "V": check_word("vram word", vram_mem.mem[a_q[i]], b_q[i]);
                "X": check_word("xr word", xr_mem.mem[a_q[i]], b_q[i]);
                "T": begin
                    bus_cycle(1'b1, xm_pkg::XM_TIMER, 0, 0, q);
                    bus_cycle(1'b1, xm_pkg::XM_TIMER, 1, 0, q_lo);
                    t = {q, q_lo};
                    d = int'(t - t_prev);
                    if (a_q[i] != 0 && (d < a_q[i] - 1 || d > a_q[i] + 1)) begin
                        $display("timer advanced by %0d ticks, expected %0d", d, a_q[i]);
                        errors++;
                        test_bad = 1'b1;
                    end
                    t_prev = t;
                end
                default: begin
                    $display("unknown operation in the test data file");
                    errors++;
                    test_bad = 1'b1;
                end
            endcase
            if (test_bad) bad_tests++;
            $display("test %0d op %c %s", i, op_q[i], test_bad ? "failed" : "ok");
        end
        asrt_fails = DUT.u_vram_port.vram_chk.fails + DUT.u_xr_port.xr_chk.fails;
        $display("%0d tests, %0d failed, %0d errors, %0d assertion failures",
                 op_q.size(), bad_tests, errors, asrt_fails);
        if (errors == 0 && asrt_fails == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end
endmodule

// File: test/xm_regs_tests.txt
# op a b c in hex: W reg bytesel data, R reg bytesel expect, P poll, I cycles
# S hblank vblank status, K mask, C clear, M wrmask, V/X addr word, T ticks
R 0 1 0f
R 0 0 00
R 1 0 00
R 7 0 00
R 9 1 00
R 5 1 00
M f
W 8 1 02
W 9 0 01
W 9 1 00
W a 0 12
W a 1 34
P
W a 0 56
W a 1 78
P
W b 0 9a
W b 1 bc
P
V 100 1234
V 102 5678
V 104 9abc
R 9 1 06
W 6 1 02
W 7 0 01
W 7 1 00
P
R a 0 12
R a 1 34
P
R a 0 56
R a 1 78
P
R b 0 9a
R b 1 bc
P
R 7 0 01
R 7 1 08
W 4 0 00
W 4 1 10
W 5 0 ca
W 5 1 fe
P
W 5 0 be
W 5 1 ef
P
R 4 1 12
X 10 cafe
X 11 beef
W 3 0 00
W 3 1 10
P
R 5 0 ca
R 5 1 fe
P
R 5 0 be
R 5 1 ef
P
R 3 1 13
W 0 1 05
M 5
R 0 1 05
W 0 1 0f
S 1 0 2a
R 0 0 08
W 1 0 55
K 55
W 1 1 33
C 33
R 1 0 55
R 1 1 2a
T 0
I 2710
T 4

// File: vlog.f
common/xm_pkg.sv
hdl/bus_sync.sv
vram_port/vram_port.sv
xr_port/xr_port.sv
hdl/sys_regs.sv
hdl/xm_regs.sv
test/xm_regs_chk.sv
test/xm_regs_tb.sv

// File: vram_port/vram_port.sv
//*********************************************************************
// vram_port
// VRAM read/write address, increment and data registers, nibble
// write mask, request generation and pre-read of the next word
//*********************************************************************

module vram_port (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xm_pkg::bus_evt_t   bus_evt_i,
    input  wire logic               vram_ack_i,
    input  wire xm_pkg::word_t      vram_data_i,
    output      xm_pkg::mem_req_t   vram_req_o,
    output      xm_pkg::wrmask_t    vram_wrmask_o,
    output      xm_pkg::vram_view_t vram_view_o,
    output      logic               vram_busy_o
);

xm_pkg::vram_view_t regs;           // readable port state
xm_pkg::byte_t      data_even;      // high byte of DATA until odd byte
logic               odd;
xm_pkg::byte_t      din;
logic               data_reg;       // DATA or DATA_2 addressed

assign odd      = bus_evt_i.bytesel;
assign din      = bus_evt_i.data;
assign data_reg = (bus_evt_i.reg_num == xm_pkg::XM_DATA) ||
                  (bus_evt_i.reg_num == xm_pkg::XM_DATA_2);

assign vram_view_o   = regs;
assign vram_wrmask_o = regs.wrmask;
assign vram_busy_o   = vram_req_o.sel;

always_ff @(posedge clk) begin
    if (reset_i) begin
        regs       <= '{wrmask: '1, default: '0};
        data_even  <= '0;
        vram_req_o <= '0;
    end else begin
        // access done, step the address that was used
        if (vram_req_o.sel && vram_ack_i) begin
            vram_req_o.sel <= 1'b0;
            vram_req_o.wr  <= 1'b0;
            if (vram_req_o.wr) begin
                regs.wr_addr <= regs.wr_addr + regs.wr_incr;
            end else begin
                regs.data    <= vram_data_i;
                regs.rd_addr <= regs.rd_addr + regs.rd_incr;
            end
        end

        if (bus_evt_i.wr_strobe) begin
            case (bus_evt_i.reg_num)
                xm_pkg::XM_SYS_CTRL: begin
                    if (odd) begin
                        regs.wrmask <= din[3:0];
                    end
                end
                xm_pkg::XM_RD_INCR: regs.rd_incr <= xm_pkg::put_byte(regs.rd_incr, odd, din);
                xm_pkg::XM_WR_INCR: regs.wr_incr <= xm_pkg::put_byte(regs.wr_incr, odd, din);
                xm_pkg::XM_WR_ADDR: regs.wr_addr <= xm_pkg::put_byte(regs.wr_addr, odd, din);
                xm_pkg::XM_RD_ADDR: begin
                    regs.rd_addr <= xm_pkg::put_byte(regs.rd_addr, odd, din);
                    if (odd) begin                          // read at new address
                        vram_req_o.sel  <= 1'b1;
                        vram_req_o.wr   <= 1'b0;
                        vram_req_o.addr <= xm_pkg::put_byte(regs.rd_addr, 1'b1, din);
                    end
                end
                xm_pkg::XM_DATA,
                xm_pkg::XM_DATA_2: begin
                    if (!odd) begin
                        data_even <= din;
                    end else begin
                        vram_req_o.sel  <= 1'b1;
                        vram_req_o.wr   <= 1'b1;
                        vram_req_o.addr <= regs.wr_addr;
                        vram_req_o.data <= {data_even, din};
                    end
                end
                default: begin
                end
            endcase
        end

        // odd byte of DATA read, fetch the next word
        if (bus_evt_i.rd_strobe && odd && data_reg) begin
            vram_req_o.sel  <= 1'b1;
            vram_req_o.wr   <= 1'b0;
            vram_req_o.addr <= regs.rd_addr;
        end
    end
end

endmodule

// File: xr_port/xr_port.sv
//*********************************************************************
// xr_port
// XR read/write address and data registers with request generation,
// addresses step by one after each acknowledged access
//*********************************************************************

module xr_port (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire xm_pkg::bus_evt_t bus_evt_i,
    input  wire logic             xr_ack_i,
    input  wire xm_pkg::word_t    xr_data_i,
    output      xm_pkg::mem_req_t xr_req_o,
    output      xm_pkg::xr_view_t xr_view_o,
    output      logic             xr_busy_o
);

xm_pkg::xr_view_t regs;
xm_pkg::byte_t    xdata_even;       // high byte of XDATA until odd byte
logic             odd;
xm_pkg::byte_t    din;

assign odd = bus_evt_i.bytesel;
assign din = bus_evt_i.data;

assign xr_view_o = regs;
assign xr_busy_o = xr_req_o.sel;

always_ff @(posedge clk) begin
    if (reset_i) begin
        regs       <= '0;
        xdata_even <= '0;
        xr_req_o   <= '0;
    end else begin
        if (xr_req_o.sel && xr_ack_i) begin
            xr_req_o.sel <= 1'b0;
            xr_req_o.wr  <= 1'b0;
            if (xr_req_o.wr) begin
                regs.wr_xaddr <= regs.wr_xaddr + 16'd1;
            end else begin
                regs.xdata    <= xr_data_i;
                regs.rd_xaddr <= regs.rd_xaddr + 16'd1;
            end
        end

        if (bus_evt_i.wr_strobe) begin
            case (bus_evt_i.reg_num)
                xm_pkg::XM_RD_XADDR: begin
                    regs.rd_xaddr <= xm_pkg::put_byte(regs.rd_xaddr, odd, din);
                    if (odd) begin
                        xr_req_o.sel  <= 1'b1;
                        xr_req_o.wr   <= 1'b0;
                        xr_req_o.addr <= xm_pkg::put_byte(regs.rd_xaddr, 1'b1, din);
                    end
                end
                xm_pkg::XM_WR_XADDR: regs.wr_xaddr <= xm_pkg::put_byte(regs.wr_xaddr, odd, din);
                xm_pkg::XM_XDATA: begin
                    if (!odd) begin
                        xdata_even <= din;
                    end else begin
                        xr_req_o.sel  <= 1'b1;
                        xr_req_o.wr   <= 1'b1;
                        xr_req_o.addr <= regs.wr_xaddr;
                        xr_req_o.data <= {xdata_even, din};
                    end
                end
                default: begin
                end
            endcase
        end

        // pre-read next XR word after XDATA read
        if (bus_evt_i.rd_strobe && odd && (bus_evt_i.reg_num == xm_pkg::XM_XDATA)) begin
            xr_req_o.sel  <= 1'b1;
            xr_req_o.wr   <= 1'b0;
            xr_req_o.addr <= regs.rd_xaddr;
        end
    end
end

endmodule
